// ==== all.f ====
vdp_pkg.sv
col_ctrl_if.sv
sync_fifo.sv
op_sequencer.sv
vector_column.sv
vector_datapath.sv
vdp_checker.sv
tb_vector_datapath.sv

// ==== Makefile ====
TOP = tb_vector_datapath

.PHONY: build run clean

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== tb_vector_datapath.sv ====
`timescale 1ns/1ns

module tb_vector_datapath;

    localparam int NUM_COL = vdp_pkg::NUM_COL;
    localparam int FIFO_DEPTH = vdp_pkg::FIFO_DEPTH;
    localparam int EW = vdp_pkg::ELEM_W;
    localparam int VW = vdp_pkg::LANES * vdp_pkg::ELEM_W;
    // vectors moved per unit of vlen over all tests, vlen at most DEPTH
    localparam int TOTAL_VECS = (11 * NUM_COL + 5) * vdp_pkg::DEPTH;
    localparam int CYCLE_LIMIT = TOTAL_VECS * 20 + 1000;

    typedef logic [VW:0] word_t;  // {last, vector}

    logic clk;
    logic rst;
    logic i_start;
    vdp_pkg::op_e i_op;
    vdp_pkg::vlen_t i_vlen;
    logic o_done;
    logic o_busy;
    vdp_pkg::vec_t i_tdata;
    logic i_tvalid;
    logic o_tready;
    vdp_pkg::vec_t o_tdata;
    logic o_tvalid;
    logic i_tready;
    logic o_tlast;

    int seed = 32'h6647_a53b;
    int ready_pct = 60;
    int err_count = 0;
    int check_total = 0;
    int test_total = 0;
    int test_fails = 0;
    int test_err0;
    string test_name;
    int done_count = 0;
    vdp_pkg::vec_t in_q[$];   // vectors waiting for the input stream
    word_t out_q[$];          // words taken from the output stream
    vdp_pkg::vec_t w_m [NUM_COL][vdp_pkg::DEPTH];
    vdp_pkg::vec_t acc_m [NUM_COL][vdp_pkg::DEPTH];

    vector_datapath #(.NUM_COL(NUM_COL), .FIFO_DEPTH(FIFO_DEPTH)) UUT (
        .clk     (clk),
        .rst     (rst),
        .i_start (i_start),
        .i_op    (i_op),
        .i_vlen  (i_vlen),
        .o_done  (o_done),
        .o_busy  (o_busy),
        .i_tdata (i_tdata),
        .i_tvalid(i_tvalid),
        .o_tready(o_tready),
        .o_tdata (o_tdata),
        .o_tvalid(o_tvalid),
        .i_tready(i_tready),
        .o_tlast (o_tlast)
    );

    bind vector_datapath vdp_checker u_checker (
        .clk     (clk),
        .rst     (rst),
        .i_done  (o_done),
        .i_busy  (o_busy),
        .i_tvalid(o_tvalid),
        .i_tready(i_tready),
        .i_tdata (o_tdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // stream source and sink, both change on the falling edge
    initial begin : stream_drive
        logic rdy;
        i_tvalid = 1'b0;
        i_tdata = '0;
        i_tready = 1'b0;
        forever begin
            @(negedge clk);
            if (o_done) begin
                done_count++;
            end
            if (rst) begin
                i_tvalid = 1'b0;
                i_tready = 1'b0;
            end else begin
                if ((in_q.size() != 0) && (($random(seed) & 3) != 0)) begin
                    i_tvalid = 1'b1;
                    i_tdata = in_q[0];
                    if (o_tready) begin
                        void'(in_q.pop_front());  // taken at the next rising edge
                    end
                end else begin
                    i_tvalid = 1'b0;
                end
                rdy = ((($random(seed) & 32'h7fff_ffff) % 100) < ready_pct);
                i_tready = rdy;
                if (rdy && o_tvalid) begin
                    out_q.push_back({o_tlast, o_tdata});
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
        $display("Finished with errors");
        $finish;
    end

    function automatic vdp_pkg::vec_t rand_vec();
        return vdp_pkg::vec_t'($random(seed));
    endfunction

    // lane-wise acc + w*x, kept to 16 bits per lane
    function automatic vdp_pkg::vec_t model_macc(
        input vdp_pkg::vec_t acc,
        input vdp_pkg::vec_t w,
        input vdp_pkg::vec_t x
    );
        vdp_pkg::vec_t res;
        int s;
        for (int l = 0; l < vdp_pkg::LANES; l++) begin
            s = int'($signed(acc[l*EW +: EW]))
                + int'($signed(w[l*EW +: EW])) * int'($signed(x[l*EW +: EW]));
            res[l*EW +: EW] = s[EW-1:0];
        end
        return res;
    endfunction

    task automatic check_vec(input string name, input vdp_pkg::vec_t exp,
                             input vdp_pkg::vec_t act);
        check_total++;
        if (act !== exp) begin
            err_count++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_total++;
        if (act !== exp) begin
            err_count++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        check_total++;
        if (act != exp) begin
            err_count++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = err_count;
        test_total++;
    endtask

    task automatic end_test();
        if (err_count == test_err0) begin
            $display("test %-22s passed", test_name);
        end else begin
            test_fails++;
            $display("test %-22s failed, %0d errors", test_name, err_count - test_err0);
        end
    endtask

    task automatic start_op(input vdp_pkg::op_e op, input vdp_pkg::vlen_t vlen);
        @(negedge clk);
        while (o_busy) @(negedge clk);
        i_start = 1'b1;
        i_op = op;
        i_vlen = vlen;
        @(negedge clk);
        i_start = 1'b0;
    endtask

    task automatic wait_done(input string name);
        while (!o_done) @(negedge clk);
        check_bit({name, " busy at done"}, 1'b0, o_busy);
    endtask

    task automatic run_op(input string name, input vdp_pkg::op_e op,
                          input vdp_pkg::vlen_t vlen);
        start_op(op, vlen);
        wait_done(name);
    endtask

    // vector c*vlen+k lands in column c, entry k
    task automatic queue_weights(input vdp_pkg::vlen_t vlen);
        vdp_pkg::vec_t v;
        for (int c = 0; c < NUM_COL; c++) begin
            for (int k = 0; k < int'(vlen); k++) begin
                v = rand_vec();
                w_m[c][k] = v;
                in_q.push_back(v);
            end
        end
    endtask

    task automatic load_weights(input vdp_pkg::vlen_t vlen);
        queue_weights(vlen);
        run_op({test_name, " load"}, vdp_pkg::OP_LOAD, vlen);
    endtask

    task automatic macc_pass(input vdp_pkg::vlen_t vlen);
        vdp_pkg::vec_t x;
        for (int k = 0; k < int'(vlen); k++) begin
            x = rand_vec();
            for (int c = 0; c < NUM_COL; c++) begin
                acc_m[c][k] = model_macc(acc_m[c][k], w_m[c][k], x);
            end
            in_q.push_back(x);
        end
        run_op({test_name, " macc"}, vdp_pkg::OP_MACC, vlen);
    endtask

    task automatic stream_out_check(input vdp_pkg::vlen_t vlen);
        word_t exp_q[$];
        word_t got;
        logic last;
        int n;
        for (int c = 0; c < NUM_COL; c++) begin
            for (int k = 0; k < int'(vlen); k++) begin
                last = (c == NUM_COL - 1) && (k == int'(vlen) - 1);
                exp_q.push_back({last, acc_m[c][k]});
                acc_m[c][k] = '0;  // entry cleared by the read
            end
        end
        n = exp_q.size();
        run_op({test_name, " streamout"}, vdp_pkg::OP_STREAMOUT, vlen);
        while (out_q.size() < n) @(negedge clk);
        for (int i = 0; i < n; i++) begin
            got = out_q.pop_front();
            check_vec({test_name, " data"}, exp_q[i][VW-1:0], got[VW-1:0]);
            check_bit({test_name, " last"}, exp_q[i][VW], got[VW]);
        end
        while (o_tvalid) @(negedge clk);
        @(negedge clk);
        check_count({test_name, " extra outputs"}, 0, out_q.size());
    endtask

    initial begin
        vdp_pkg::vlen_t vlen;
        int done0;
        rst = 1'b1;
        i_start = 1'b0;
        i_op = vdp_pkg::OP_LOAD;
        i_vlen = vdp_pkg::vlen_t'(1);
        for (int c = 0; c < NUM_COL; c++) begin
            for (int k = 0; k < vdp_pkg::DEPTH; k++) begin
                acc_m[c][k] = '0;
            end
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;

        begin_test("reset_state");
        @(negedge clk);
        check_bit("reset_state done", 1'b0, o_done);
        check_bit("reset_state busy", 1'b0, o_busy);
        check_bit("reset_state tvalid", 1'b0, o_tvalid);
        end_test();

        begin_test("load_stream_zero");
        vlen = vdp_pkg::vlen_t'(1 + ($random(seed) & 3));
        load_weights(vlen);
        stream_out_check(vlen);
        end_test();

        begin_test("load_macc_stream");
        vlen = vdp_pkg::vlen_t'(1 + ($random(seed) & 3));
        load_weights(vlen);
        macc_pass(vlen);
        stream_out_check(vlen);
        end_test();

        begin_test("macc_accumulate_clear");
        vlen = vdp_pkg::vlen_t'(1 + ($random(seed) & 3));
        load_weights(vlen);
        macc_pass(vlen);
        macc_pass(vlen);
        stream_out_check(vlen);
        stream_out_check(vlen);  // all zero after the first read
        end_test();

        begin_test("backpressure");
        ready_pct = 25;
        vlen = vdp_pkg::vlen_t'(vdp_pkg::DEPTH);
        load_weights(vlen);
        macc_pass(vlen);
        stream_out_check(vlen);
        ready_pct = 60;
        end_test();

        begin_test("start_while_busy");
        vlen = vdp_pkg::vlen_t'(1 + ($random(seed) & 3));
        done0 = done_count;
        start_op(vdp_pkg::OP_LOAD, vlen);  // no data queued yet, so it stays busy
        check_bit("start_while_busy busy", 1'b1, o_busy);
        i_start = 1'b1;
        i_op = vdp_pkg::OP_STREAMOUT;
        i_vlen = vdp_pkg::vlen_t'(vdp_pkg::DEPTH);
        @(negedge clk);
        i_start = 1'b0;
        queue_weights(vlen);
        wait_done("start_while_busy load");
        macc_pass(vlen);
        stream_out_check(vlen);
        check_count("start_while_busy done pulses", 3, done_count - done0);
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_total, test_fails, check_total, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== vdp_checker.sv ====
`timescale 1ns/1ns

module vdp_checker (
    input logic clk,
    input logic rst,
    input logic i_done,
    input logic i_busy,
    input logic i_tvalid,
    input logic i_tready,
    input vdp_pkg::vec_t i_tdata
);

    // output fifo stays empty while reset is held
    a_no_valid_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> !i_tvalid)
        else $error("o_tvalid high during reset");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) i_done |=> !i_done)
        else $error("o_done longer than one cycle");

    a_done_after_busy: assert property (@(posedge clk) disable iff (rst)
        i_done |-> $past(i_busy))
        else $error("o_done without a busy cycle before it");

    // head word held while the consumer stalls
    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        (i_tvalid && !i_tready) |=> (i_tvalid && $stable(i_tdata)))
        else $error("o_tdata changed while stalled");

endmodule

// ==== vector_datapath.sv ====
`timescale 1ns/1ns

module vector_datapath #(
    parameter int NUM_COL = vdp_pkg::NUM_COL,
    parameter int FIFO_DEPTH = vdp_pkg::FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst,
    // command
    input  logic i_start,
    input  vdp_pkg::op_e i_op,
    input  vdp_pkg::vlen_t i_vlen,
    output logic o_done,
    output logic o_busy,
    // stream in
    input  vdp_pkg::vec_t i_tdata,
    input  logic i_tvalid,
    output logic o_tready,
    // stream out
    output vdp_pkg::vec_t o_tdata,
    output logic o_tvalid,
    input  logic i_tready,
    output logic o_tlast
);

    logic [vdp_pkg::LANES*vdp_pkg::ELEM_W:0] in_word;  // last bit unused on input
    logic in_empty;
    logic in_full;
    logic in_pop;
    logic out_push;
    logic out_pop;
    logic out_empty;
    logic out_last;
    vdp_pkg::vec_t out_data;
    vdp_pkg::vec_t [NUM_COL-1:0] acc_bus;

    col_ctrl_if #(.N_COL(NUM_COL)) ctrl_if ();

    assign o_tready = !in_full;
    assign o_tvalid = !out_empty;
    assign out_pop = o_tvalid && i_tready;

    sync_fifo #(.DEPTH_P(FIFO_DEPTH)) u_in_fifo (
        .clk    (clk),
        .rst    (rst),
        .i_push (i_tvalid && !in_full),
        .i_pop  (in_pop),
        .i_din  ({1'b0, i_tdata}),
        .o_dout (in_word),
        .o_empty(in_empty),
        .o_full (in_full)
    );

    op_sequencer #(.NUM_COL(NUM_COL), .CREDITS(FIFO_DEPTH)) u_seq (
        .clk       (clk),
        .rst       (rst),
        .i_start   (i_start),
        .i_op      (i_op),
        .i_vlen    (i_vlen),
        .i_in_valid(!in_empty),
        .i_in_data (in_word[vdp_pkg::LANES*vdp_pkg::ELEM_W-1:0]),
        .o_in_pop  (in_pop),
        .i_out_pop (out_pop),
        .i_acc     (acc_bus),
        .o_out_push(out_push),
        .o_out_data(out_data),
        .o_out_last(out_last),
        .o_done    (o_done),
        .o_busy    (o_busy),
        .ctrl      (ctrl_if)
    );

    // input vector broadcast to every column
    for (genvar c = 0; c < NUM_COL; c++) begin : g_col
        vector_column #(.COL_IDX(c)) u_col (
            .clk  (clk),
            .rst  (rst),
            .ctrl (ctrl_if),
            .o_acc(acc_bus[c])
        );
    end

    sync_fifo #(.DEPTH_P(FIFO_DEPTH)) u_out_fifo (
        .clk    (clk),
        .rst    (rst),
        .i_push (out_push),  // credits keep this below full
        .i_pop  (out_pop),
        .i_din  ({out_last, out_data}),
        .o_dout ({o_tlast, o_tdata}),
        .o_empty(out_empty),
        .o_full ()
    );

endmodule

// ==== vector_column.sv ====
`timescale 1ns/1ns

module vector_column #(
    parameter int COL_IDX = 0
) (
    input  logic clk,
    input  logic rst,
    col_ctrl_if.col ctrl,
    output vdp_pkg::vec_t o_acc
);

    localparam int EW = vdp_pkg::ELEM_W;

    vdp_pkg::vec_t w_mem [vdp_pkg::DEPTH];
    vdp_pkg::vec_t acc_mem [vdp_pkg::DEPTH];
    vdp_pkg::vec_t w_rd;
    vdp_pkg::vec_t acc_rd;
    vdp_pkg::vec_t mac_sum;
    vdp_pkg::vec_t mac_q;
    vdp_pkg::idx_t mac_addr_q;
    logic mac_vld_q;

    // one lane, result wraps to the element width
    function automatic vdp_pkg::elem_t mac_elem(
        input vdp_pkg::elem_t a,
        input vdp_pkg::elem_t w,
        input vdp_pkg::elem_t x
    );
        vdp_pkg::elem_t prod;
        prod = vdp_pkg::elem_t'(w * x);
        return vdp_pkg::elem_t'(a + prod);
    endfunction

    assign w_rd = w_mem[ctrl.addr];
    assign acc_rd = acc_mem[ctrl.addr];
    assign o_acc = acc_rd;  // streamout source

    always_comb begin
        for (int l = 0; l < vdp_pkg::LANES; l++) begin
            mac_sum[l*EW +: EW] = mac_elem(acc_rd[l*EW +: EW], w_rd[l*EW +: EW],
                                           ctrl.x[l*EW +: EW]);
        end
    end

    // weight half of the register file
    always_ff @(posedge clk) begin
        if (ctrl.wr_mask[COL_IDX]) begin
            w_mem[ctrl.addr] <= ctrl.x;
        end
    end

    // mac pipeline stage
    always_ff @(posedge clk) begin
        if (rst) begin
            mac_vld_q <= 1'b0;
        end else begin
            mac_vld_q <= ctrl.macc_en;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.macc_en) begin
            mac_q <= mac_sum;
            mac_addr_q <= ctrl.addr;
        end
    end

    // accumulator half, write back one cycle after the mac
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < vdp_pkg::DEPTH; e++) begin
                acc_mem[e] <= '0;
            end
        end else begin
            if (mac_vld_q) begin
                acc_mem[mac_addr_q] <= mac_q;
            end
            // read and clear, never in the same op as a write back
            if (ctrl.rd_mask[COL_IDX]) begin
                acc_mem[ctrl.addr] <= '0;
            end
        end
    end

endmodule

// ==== op_sequencer.sv ====
`timescale 1ns/1ns

module op_sequencer #(
    parameter int NUM_COL = vdp_pkg::NUM_COL,
    parameter int CREDITS = vdp_pkg::FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  logic i_start,
    input  vdp_pkg::op_e i_op,
    input  vdp_pkg::vlen_t i_vlen,
    input  logic i_in_valid,
    input  vdp_pkg::vec_t i_in_data,
    output logic o_in_pop,
    input  logic i_out_pop,
    input  vdp_pkg::vec_t [NUM_COL-1:0] i_acc,
    output logic o_out_push,
    output vdp_pkg::vec_t o_out_data,
    output logic o_out_last,
    output logic o_done,
    output logic o_busy,
    col_ctrl_if.seq ctrl
);

    localparam int CRED_W = $clog2(CREDITS + 1);

    typedef enum logic {S_IDLE, S_RUN} state_e;

    state_e state_q;
    vdp_pkg::op_e op_q;
    vdp_pkg::vlen_t vlen_q;
    vdp_pkg::idx_t entry_q;
    vdp_pkg::col_t col_q;
    logic [CRED_W-1:0] credit_q;
    logic done_q;
    logic [NUM_COL-1:0] col_sel;
    logic entry_last;
    logic col_last;
    logic is_stream;
    logic step;
    logic op_end;

    assign entry_last = ({1'b0, entry_q} == vlen_q - 3'd1);
    assign col_last = (col_q == vdp_pkg::col_t'(NUM_COL - 1));
    assign is_stream = (op_q == vdp_pkg::OP_STREAMOUT);
    assign col_sel = NUM_COL'(1) << col_q;

    // streamout is paced by credits, load and macc by input data
    assign step = (state_q == S_RUN) && (is_stream ? (credit_q != '0) : i_in_valid);
    assign op_end = step && entry_last && ((op_q == vdp_pkg::OP_MACC) || col_last);

    assign o_in_pop = step && !is_stream;
    assign ctrl.x = i_in_data;
    assign ctrl.addr = entry_q;
    assign ctrl.macc_en = step && (op_q == vdp_pkg::OP_MACC);
    assign ctrl.wr_mask = (step && (op_q == vdp_pkg::OP_LOAD)) ? col_sel : '0;
    assign ctrl.rd_mask = (step && is_stream) ? col_sel : '0;

    assign o_out_push = step && is_stream;
    assign o_out_data = i_acc[col_q];            // supplier column
    assign o_out_last = entry_last && col_last;
    assign o_done = done_q;
    assign o_busy = (state_q == S_RUN);

    // one credit per free slot in the output fifo
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_q <= CRED_W'(CREDITS);
        end else begin
            credit_q <= credit_q - CRED_W'(o_out_push) + CRED_W'(i_out_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            op_q <= vdp_pkg::OP_LOAD;
            vlen_q <= '0;
            entry_q <= '0;
            col_q <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= op_end;
            case (state_q)
                S_IDLE: begin
                    if (i_start) begin  // start only seen here
                        state_q <= S_RUN;
                        op_q <= i_op;
                        vlen_q <= i_vlen;
                        entry_q <= '0;
                        col_q <= '0;
                    end
                end
                S_RUN: begin
                    if (step) begin
                        if (entry_last) begin
                            entry_q <= '0;
                            col_q <= col_last ? '0 : col_q + 1'b1;
                        end else begin
                            entry_q <= entry_q + 1'b1;
                        end
                    end
                    if (op_end) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter int DEPTH_P = vdp_pkg::FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  logic i_push,
    input  logic i_pop,
    input  logic [vdp_pkg::LANES*vdp_pkg::ELEM_W:0] i_din,  // {last, vector}
    output logic [vdp_pkg::LANES*vdp_pkg::ELEM_W:0] o_dout,
    output logic o_empty,
    output logic o_full
);

    localparam int PTR_W = (DEPTH_P > 1) ? $clog2(DEPTH_P) : 1;
    localparam int CNT_W = $clog2(DEPTH_P + 1);

    logic [vdp_pkg::LANES*vdp_pkg::ELEM_W:0] mem [DEPTH_P];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic push_ok;
    logic pop_ok;

    assign push_ok = i_push && !o_full;
    assign pop_ok = i_pop && !o_empty;
    assign o_empty = (count == '0);
    assign o_full = (count == CNT_W'(DEPTH_P));
    assign o_dout = mem[rd_ptr];  // head, read without a clock

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH_P - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH_P - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
        end
    end

endmodule

// ==== col_ctrl_if.sv ====
`timescale 1ns/1ns

interface col_ctrl_if #(
    parameter int N_COL = vdp_pkg::NUM_COL
);
    vdp_pkg::vec_t x;          // broadcast input vector
    logic [N_COL-1:0] wr_mask; // weight write, one bit per column
    logic macc_en;             // mac in every column
    logic [N_COL-1:0] rd_mask; // read and clear accumulator
    vdp_pkg::idx_t addr;

    // sequencer side
    modport seq (
        output x, wr_mask, macc_en, rd_mask, addr
    );

    modport col (
        input x, wr_mask, macc_en, rd_mask, addr
    );

endinterface

// ==== vdp_pkg.sv ====
package vdp_pkg;

    // element and vector geometry
    localparam int ELEM_W = 16;
    localparam int LANES = 2;

    // default sizes, overridden from the top level
    localparam int NUM_COL = 2;
    localparam int DEPTH = 4;      // weight and acc entries per column
    localparam int FIFO_DEPTH = 4;

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic [LANES*ELEM_W-1:0] vec_t;  // lane 0 in the low bits
    typedef logic [1:0] idx_t;               // register entry
    typedef logic [2:0] vlen_t;              // 1..DEPTH
    typedef logic [0:0] col_t;

    typedef enum logic [1:0] {
        OP_LOAD = 2'd0,
        OP_MACC = 2'd1,
        OP_STREAMOUT = 2'd2
    } op_e;

endpackage
